// File: rtl/bcm_pkg.sv
// Shared definitions for the basic clock module
// Address map, register field layout and the types passed between blocks
// Referenced by scoped name from every RTL file

package bcm_pkg;

  // --------------------------------------------------
  // Peripheral bus types
  // --------------------------------------------------

  // Word address as seen on the peripheral bus
  typedef logic [13:0] per_addr_t;

  // One data word
  typedef logic [15:0] per_data_t;

  // Byte write strobes, bit 0 for the low byte
  typedef logic [1:0]  per_we_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------

  // Byte base address, aligned to the decoder width
  localparam logic [14:0] bcm_base_addr  = 15'h0050;

  // Number of byte address bits handled by the local decoder
  localparam int          bcm_dec_wd     = 4;

  // Byte offsets, bit 0 picks the byte lane
  localparam logic [3:0]  bcsctl1_offset = 4'h7;
  localparam logic [3:0]  bcsctl2_offset = 4'h8;

  // --------------------------------------------------
  // Register fields
  // --------------------------------------------------

  // DIVA only in BCSCTL1
  localparam logic [7:0]  bcsctl1_mask   = 8'h30;
  // SELS and DIVS in BCSCTL2, SELM and DIVM read as zero
  localparam logic [7:0]  bcsctl2_mask   = 8'h0E;

  // Field positions
  localparam int          diva_lsb       = 4;
  localparam int          divs_lsb       = 1;
  localparam int          sels_bit       = 3;

  // Divide ratio as coded in DIVA and DIVS
  typedef enum logic [1:0] {
    div_1 = 2'd0,
    div_2 = 2'd1,
    div_4 = 2'd2,
    div_8 = 2'd3
  } div_sel_t;

  // Decoded configuration for the clock logic
  typedef struct packed {
    div_sel_t diva;
    div_sel_t divs;
    logic     sels;
  } bcm_cfg_t;

endpackage

// File: rtl/bcm_regs.sv
// BCSCTL1 and BCSCTL2 peripheral registers
// Decodes the bus, stores the writable fields and returns them on reads

`timescale 1ns/1ns

module bcm_regs (
  input  logic                mclk,
  input  logic                puc_rst,
  // Peripheral bus
  input  logic                per_en,
  input  bcm_pkg::per_addr_t  per_addr,
  input  bcm_pkg::per_we_t    per_we,
  input  bcm_pkg::per_data_t  per_din,
  output bcm_pkg::per_data_t  per_dout,
  // Decoded fields for the clock logic
  output bcm_pkg::bcm_cfg_t   cfg
);

  // --------------------------------------------------
  // Address decoder
  // --------------------------------------------------

  logic                               reg_sel;
  logic [bcm_pkg::bcm_dec_wd-2:0]     reg_addr;
  logic                               reg_lo_write;
  logic                               reg_hi_write;
  logic                               reg_read;
  logic                               bcsctl1_hit;
  logic                               bcsctl2_hit;

  // Block selected when the upper word address bits match the base
  assign reg_sel = per_en &
                   (per_addr[13:bcm_pkg::bcm_dec_wd-1] ==
                    bcm_pkg::bcm_base_addr[14:bcm_pkg::bcm_dec_wd]);

  // Local word index inside the block
  assign reg_addr = per_addr[bcm_pkg::bcm_dec_wd-2:0];

  // Word hits, offsets are byte based
  assign bcsctl1_hit = (reg_addr == bcm_pkg::bcsctl1_offset[bcm_pkg::bcm_dec_wd-1:1]);
  assign bcsctl2_hit = (reg_addr == bcm_pkg::bcsctl2_offset[bcm_pkg::bcm_dec_wd-1:1]);

  // Byte strobes
  assign reg_lo_write = reg_sel & per_we[0];
  assign reg_hi_write = reg_sel & per_we[1];
  // A read is any selected cycle without write strobes
  assign reg_read     = reg_sel & ~|per_we;

  // --------------------------------------------------
  // Register storage
  // --------------------------------------------------

  logic [7:0]          bcsctl1;
  logic [7:0]          bcsctl2;
  logic                bcsctl1_wr;
  logic                bcsctl2_wr;
  logic [7:0]          bcsctl1_nxt;
  logic [7:0]          bcsctl2_nxt;

  // Lane of each register follows bit 0 of its offset
  assign bcsctl1_wr  = bcsctl1_hit &
                       (bcm_pkg::bcsctl1_offset[0] ? reg_hi_write : reg_lo_write);
  assign bcsctl2_wr  = bcsctl2_hit &
                       (bcm_pkg::bcsctl2_offset[0] ? reg_hi_write : reg_lo_write);
  assign bcsctl1_nxt = bcm_pkg::bcsctl1_offset[0] ? per_din[15:8] : per_din[7:0];
  assign bcsctl2_nxt = bcm_pkg::bcsctl2_offset[0] ? per_din[15:8] : per_din[7:0];

  // Unused bits are kept at zero
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl1 <= 8'h00;
    end else if (bcsctl1_wr) begin
      bcsctl1 <= bcsctl1_nxt & bcm_pkg::bcsctl1_mask;
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl2 <= 8'h00;
    end else if (bcsctl2_wr) begin
      bcsctl2 <= bcsctl2_nxt & bcm_pkg::bcsctl2_mask;
    end
  end

  // --------------------------------------------------
  // Read mux and field unpacking
  // --------------------------------------------------

  bcm_pkg::per_data_t  bcsctl1_rd;
  bcm_pkg::per_data_t  bcsctl2_rd;

  // Each register placed in its own lane, zero when not read
  assign bcsctl1_rd = !(reg_read & bcsctl1_hit) ? 16'h0000 :
                      bcm_pkg::bcsctl1_offset[0] ? {bcsctl1, 8'h00} : {8'h00, bcsctl1};
  assign bcsctl2_rd = !(reg_read & bcsctl2_hit) ? 16'h0000 :
                      bcm_pkg::bcsctl2_offset[0] ? {bcsctl2, 8'h00} : {8'h00, bcsctl2};

  assign per_dout = bcsctl1_rd | bcsctl2_rd;

  assign cfg.diva = bcm_pkg::div_sel_t'(bcsctl1[bcm_pkg::diva_lsb +: 2]);
  assign cfg.divs = bcm_pkg::div_sel_t'(bcsctl2[bcm_pkg::divs_lsb +: 2]);
  assign cfg.sels = bcsctl2[bcm_pkg::sels_bit];

  // Idle bus never sees read data
  a_dout_idle: assert property (@(posedge mclk) disable iff (puc_rst)
    !per_en |-> (per_dout == 16'h0000));

endmodule

// File: rtl/bcm_clk_src.sv
// Tick sources for the ACLK and SMCLK dividers
// Synchronises lfxt_clk and cpu_en into mclk and detects LFXT rising edges

`timescale 1ns/1ns

module bcm_clk_src (
  input  logic               mclk,
  input  logic               puc_rst,
  input  logic               lfxt_clk,
  input  logic               cpu_en,
  input  logic               oscoff,
  input  logic               scg1,
  input  bcm_pkg::bcm_cfg_t  cfg,
  output logic               aclk_tick,
  output logic               smclk_tick,
  output logic               cpu_en_s
);

  logic [1:0] lfxt_sync;
  logic [1:0] cpu_en_sync;
  logic       lfxt_dly;
  logic       lfxt_rise;
  logic       lfxt_tick;

  // --------------------------------------------------
  // Synchronisers
  // --------------------------------------------------

  // Two flops each, output on the second stage
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      lfxt_sync   <= 2'b00;
      cpu_en_sync <= 2'b00;
      lfxt_dly    <= 1'b0;
    end else begin
      lfxt_sync   <= {lfxt_sync[0], lfxt_clk};
      cpu_en_sync <= {cpu_en_sync[0], cpu_en};
      // Previous synchronised level for edge detection
      lfxt_dly    <= lfxt_sync[1];
    end
  end

  assign cpu_en_s = cpu_en_sync[1];

  // --------------------------------------------------
  // Tick generation
  // --------------------------------------------------

  // One mclk cycle per LFXT rising edge
  assign lfxt_rise = lfxt_sync[1] & ~lfxt_dly;

  // OSCOFF stops the crystal unless SMCLK runs from it
  assign lfxt_tick = lfxt_rise & ~(oscoff & ~cfg.sels);

  assign aclk_tick = lfxt_tick;

  // SMCLK source is MCLK (every cycle) or LFXT, SCG1 turns it off
  assign smclk_tick = ~scg1 & (cfg.sels ? lfxt_tick : 1'b1);

  // Edge pulse cannot repeat back to back
  a_aclk_tick_single: assert property (@(posedge mclk) disable iff (puc_rst)
    aclk_tick |=> !aclk_tick);

endmodule

// File: rtl/bcm_clk_div.sv
// Clock enable divider, divide by 1, 2, 4 or 8
// Counts input ticks and emits a registered one-cycle enable per period
// One instance each for ACLK and SMCLK

`timescale 1ns/1ns

module bcm_clk_div (
  input  logic               mclk,
  input  logic               puc_rst,
  // Source tick, one cycle wide
  input  logic               tick,
  // Synchronised CPU enable
  input  logic               run,
  // Divide ratio from the register block
  input  bcm_pkg::div_sel_t  div,
  output logic               en
);

  logic [2:0] cnt;
  logic       period_end;
  logic       en_nxt;

  // --------------------------------------------------
  // Tick counter
  // --------------------------------------------------

  // Frozen for div_1, period end then decided by the tick alone
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cnt <= 3'd0;
    end else if (tick && (div != bcm_pkg::div_1)) begin
      cnt <= cnt + 3'd1;
    end
  end

  // --------------------------------------------------
  // Period detection
  // --------------------------------------------------

  // Last tick of a period sees the low counter bits all ones
  always_comb begin
    case (div)
      bcm_pkg::div_1: period_end = 1'b1;
      bcm_pkg::div_2: period_end = cnt[0];
      bcm_pkg::div_4: period_end = &cnt[1:0];
      bcm_pkg::div_8: period_end = &cnt[2:0];
      default:        period_end = 1'b0;
    endcase
  end

  assign en_nxt = tick & period_end & run;

  // Registered enable, high for the cycle after the qualifying tick
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      en <= 1'b0;
    end else begin
      en <= en_nxt;
    end
  end

  // Counter only moves on ticks
  a_cnt_on_tick: assert property (@(posedge mclk) disable iff (puc_rst)
    !tick |=> $stable(cnt));

endmodule

// File: rtl/bcm_top.sv
// Basic clock module top level
// Register block, clock sources and the ACLK and SMCLK enable dividers

`timescale 1ns/1ns

module bcm_top (
  input  logic                mclk,
  input  logic                puc_rst,
  // Slow crystal clock, asynchronous to mclk
  input  logic                lfxt_clk,
  // CPU enable pin, asynchronous
  input  logic                cpu_en,
  // Status register low power bits
  input  logic                oscoff,
  input  logic                scg1,
  // Peripheral bus
  input  logic                per_en,
  input  bcm_pkg::per_addr_t  per_addr,
  input  bcm_pkg::per_we_t    per_we,
  input  bcm_pkg::per_data_t  per_din,
  output bcm_pkg::per_data_t  per_dout,
  // Clock enables
  output logic                aclk_en,
  output logic                smclk_en,
  output logic                cpu_en_s
);

  bcm_pkg::bcm_cfg_t cfg;
  logic              aclk_tick;
  logic              smclk_tick;

  // --------------------------------------------------
  // Control registers
  // --------------------------------------------------

  bcm_regs regs_inst (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_en   (per_en),
    .per_addr (per_addr),
    .per_we   (per_we),
    .per_din  (per_din),
    .per_dout (per_dout),
    .cfg      (cfg)
  );

  // --------------------------------------------------
  // Clock sources
  // --------------------------------------------------

  bcm_clk_src clk_src_inst (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .lfxt_clk   (lfxt_clk),
    .cpu_en     (cpu_en),
    .oscoff     (oscoff),
    .scg1       (scg1),
    .cfg        (cfg),
    .aclk_tick  (aclk_tick),
    .smclk_tick (smclk_tick),
    .cpu_en_s   (cpu_en_s)
  );

  // --------------------------------------------------
  // Dividers
  // --------------------------------------------------

  // ACLK divided by DIVA
  bcm_clk_div aclk_div_inst (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .tick    (aclk_tick),
    .run     (cpu_en_s),
    .div     (cfg.diva),
    .en      (aclk_en)
  );

  // SMCLK divided by DIVS
  bcm_clk_div smclk_div_inst (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .tick    (smclk_tick),
    .run     (cpu_en_s),
    .div     (cfg.divs),
    .en      (smclk_en)
  );

endmodule

// File: tests/bcm_tb.sv
// Directed testbench for the basic clock module
// Covers register access, ACLK and SMCLK division, OSCOFF, SCG1 and CPU enable

`timescale 1ns/1ns

module bcm_tb;

  logic               mclk;
  logic               puc_rst;
  logic               lfxt_clk;
  logic               cpu_en;
  logic               oscoff;
  logic               scg1;
  logic               per_en;
  bcm_pkg::per_addr_t per_addr;
  bcm_pkg::per_we_t   per_we;
  bcm_pkg::per_data_t per_din;
  bcm_pkg::per_data_t per_dout;
  logic               aclk_en;
  logic               smclk_en;
  logic               cpu_en_s;

  integer seed = 92;
  int     errors = 0;
  int     checks = 0;
  // Rising LFXT edges still to generate
  int     lfxt_left = 0;

  bcm_top bcm_top_inst (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .lfxt_clk (lfxt_clk),
    .cpu_en   (cpu_en),
    .oscoff   (oscoff),
    .scg1     (scg1),
    .per_en   (per_en),
    .per_addr (per_addr),
    .per_we   (per_we),
    .per_din  (per_din),
    .per_dout (per_dout),
    .aclk_en  (aclk_en),
    .smclk_en (smclk_en),
    .cpu_en_s (cpu_en_s)
  );

  // --------------------------------------------------
  // Clock and LFXT generator
  // --------------------------------------------------

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;
  end

  // Toggles every 5 mclk cycles, stops low once the edge budget is spent
  initial begin
    forever begin
      repeat (5) @(posedge mclk);
      if (lfxt_clk || (lfxt_left > 0)) begin
        if (!lfxt_clk) lfxt_left = lfxt_left - 1;
        lfxt_clk <= ~lfxt_clk;
      end
    end
  end

  // --------------------------------------------------
  // Run control and compare tasks
  // --------------------------------------------------

  task automatic finish_run();
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic cmp_data(input string name, input bcm_pkg::per_data_t got,
                          input bcm_pkg::per_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic cmp_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  // Reset for 2 cycles with all control inputs idle
  task automatic apply_reset(input logic cpu_en_val);
    @(posedge mclk);
    puc_rst   <= 1'b1;
    cpu_en    <= cpu_en_val;
    oscoff    <= 1'b0;
    scg1      <= 1'b0;
    lfxt_clk  <= 1'b0;
    lfxt_left = 0;
    repeat (2) @(posedge mclk);
    puc_rst   <= 1'b0;
  endtask

  // --------------------------------------------------
  // Bus and wait tasks
  // --------------------------------------------------

  task automatic bus_write(input bcm_pkg::per_addr_t addr, input bcm_pkg::per_we_t we,
                           input bcm_pkg::per_data_t data);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_addr <= addr;
    per_we   <= we;
    per_din  <= data;
    @(posedge mclk);
    per_en   <= 1'b0;
    per_we   <= 2'b00;
  endtask

  // Read data is combinational, taken mid cycle
  task automatic bus_read(input bcm_pkg::per_addr_t addr, output bcm_pkg::per_data_t data);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_addr <= addr;
    per_we   <= 2'b00;
    @(negedge mclk);
    data = per_dout;
    @(posedge mclk);
    per_en   <= 1'b0;
  endtask

  // Both enables counted over a fixed window of cycles
  task automatic count_pulses(input int cycles, output int aclk_n, output int smclk_n);
    aclk_n  = 0;
    smclk_n = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge mclk);
      aclk_n  += aclk_en;
      smclk_n += smclk_en;
    end
  endtask

  task automatic wait_cpu_en_s();
    int n;
    n = 0;
    @(negedge mclk);
    while (!cpu_en_s && (n <= 20)) begin
      n++;
      @(negedge mclk);
    end
    if (!cpu_en_s) begin
      errors++;
      $display("Timeout while waiting for cpu_en_s to rise");
      finish_run();
    end
  endtask

  task automatic wait_smclk_pulse();
    int n;
    n = 0;
    @(negedge mclk);
    while (!smclk_en && (n <= 32)) begin
      n++;
      @(negedge mclk);
    end
    if (!smclk_en) begin
      errors++;
      $display("Timeout while waiting for the first smclk_en pulse");
      finish_run();
    end
  endtask

  // Emits a number of LFXT rising edges and counts the enables meanwhile
  task automatic run_lfxt(input int edges, output int aclk_n, output int smclk_n);
    lfxt_left = edges;
    count_pulses(edges * 10 + 20, aclk_n, smclk_n);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_regs();
    bcm_pkg::per_data_t rd;
    bcm_pkg::per_data_t d1;
    bcm_pkg::per_data_t d2;
    int                 rnd;
    apply_reset(1'b1);
    bus_read(14'h002B, rd);
    cmp_data("bcsctl1 after reset", rd, 16'h0000);
    bus_read(14'h002C, rd);
    cmp_data("bcsctl2 after reset", rd, 16'h0000);
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      d1  = rnd[15:0];
      d2  = rnd[31:16];
      bus_write(14'h002B, 2'b10, d1);
      bus_write(14'h002C, 2'b01, d2);
      // BCSCTL1 sits in the high lane, BCSCTL2 in the low lane
      bus_read(14'h002B, rd);
      cmp_data("bcsctl1", rd, {d1[15:8] & 8'h30, 8'h00});
      bus_read(14'h002C, rd);
      cmp_data("bcsctl2", rd, {8'h00, d2[7:0] & 8'h0E});
      bus_read(14'h002A, rd);
      cmp_data("unmapped word", rd, 16'h0000);
    end
  endtask

  task automatic test_aclk_div();
    int a;
    int s;
    for (int r = 0; r < 4; r++) begin
      apply_reset(1'b1);
      bus_write(14'h002B, 2'b10, 16'(r) << 12);
      wait_cpu_en_s();
      run_lfxt(16, a, s);
      cmp_count("aclk_en", a, 16 >> r);
    end
  endtask

  task automatic test_smclk_mclk();
    int a;
    int s;
    for (int r = 0; r < 4; r++) begin
      apply_reset(1'b1);
      bus_write(14'h002C, 2'b01, 16'(r) << 1);
      wait_cpu_en_s();
      wait_smclk_pulse();
      count_pulses(64, a, s);
      cmp_count("smclk_en", s, 64 >> r);
      // SCG1 stops the tick stream
      @(posedge mclk);
      scg1 <= 1'b1;
      repeat (3) @(posedge mclk);
      count_pulses(64, a, s);
      cmp_count("smclk_en scg1", s, 0);
    end
  endtask

  task automatic test_smclk_lfxt();
    int a;
    int s;
    for (int r = 0; r < 4; r++) begin
      apply_reset(1'b1);
      bus_write(14'h002C, 2'b01, 16'h0008 | (16'(r) << 1));
      wait_cpu_en_s();
      run_lfxt(16, a, s);
      cmp_count("smclk_en lfxt", s, 16 >> r);
      cmp_count("aclk_en lfxt", a, 16);
    end
    // OSCOFF with SMCLK from MCLK, crystal stopped
    apply_reset(1'b1);
    @(posedge mclk);
    oscoff <= 1'b1;
    wait_cpu_en_s();
    run_lfxt(16, a, s);
    cmp_count("aclk_en oscoff", a, 0);
    // SMCLK from LFXT keeps the crystal running
    bus_write(14'h002C, 2'b01, 16'h0008);
    run_lfxt(16, a, s);
    cmp_count("aclk_en oscoff sels", a, 16);
  endtask

  task automatic test_cpu_en();
    int a;
    int s;
    apply_reset(1'b0);
    run_lfxt(16, a, s);
    cmp_count("aclk_en cpu off", a, 0);
    cmp_count("smclk_en cpu off", s, 0);
    @(posedge mclk);
    cpu_en <= 1'b1;
    wait_cpu_en_s();
    run_lfxt(16, a, s);
    cmp_count("aclk_en cpu on", a, 16);
    cmp_count("smclk_en cpu on", s, 180);
  endtask

  initial begin
    puc_rst  = 1'b1;
    lfxt_clk = 1'b0;
    cpu_en   = 1'b0;
    oscoff   = 1'b0;
    scg1     = 1'b0;
    per_en   = 1'b0;
    per_addr = '0;
    per_we   = '0;
    per_din  = '0;
    test_regs();
    test_aclk_div();
    test_smclk_mclk();
    test_smclk_lfxt();
    test_cpu_en();
    finish_run();
  end

endmodule

// File: bcm.f
rtl/bcm_pkg.sv
rtl/bcm_regs.sv
rtl/bcm_clk_src.sv
rtl/bcm_clk_div.sv
rtl/bcm_top.sv
tests/bcm_tb.sv

// File: Bender.yml
package:
  name: bcm

sources:
  - rtl/bcm_pkg.sv
  - rtl/bcm_regs.sv
  - rtl/bcm_clk_src.sv
  - rtl/bcm_clk_div.sv
  - rtl/bcm_top.sv
  - target: test
    files:
      - tests/bcm_tb.sv
